/* rob.f */
+incdir+tests
verilog/uopPkg.sv
verilog/robPkg.sv
verilog/robIfc.sv
verilog/robDataRam.sv
verilog/robWbTracker.sv
verilog/robCore.sv
verilog/robTop.sv
tests/robTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module robTb -f rob.f
./obj_dir/VrobTb | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tests/robModel.svh */
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// one operation in flight, as the testbench expects it
typedef struct {
    logic [PTR_W-1:0] ptr;
    robPkg::robEntryT f;
    bit               done;
} modelEntryT;

// oldest entry at the front
modelEntryT inFlight[$];
// squashed entries, youngest first, waiting for the walk
modelEntryT squashed[$];

logic [31:0] lfsrState = 32'd67580;

// galois form, taps 32 22 2 1
function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsrState = stepLfsr(lfsrState);
        v = {v[30:0], lfsrState[0]};
    end
    return v;
endfunction

function automatic robPkg::robEntryT randomEntry();
    robPkg::robEntryT e;
    logic [1:0] kind;
    e.we = 1'(takeBits(1));
    kind = 2'(takeBits(2));
    // spare encoding folds into no memory access
    e.memKind = (kind == 2'd3) ? uopPkg::memNone : uopPkg::memKindE'(kind);
    e.vrd = uopPkg::VREG_WIDTH'(takeBits(uopPkg::VREG_WIDTH));
    e.prd = uopPkg::PREG_WIDTH'(takeBits(uopPkg::PREG_WIDTH));
    return e;
endfunction

// first entry still waiting for writeback, scanning from start
function automatic int findOpen(input int start);
    int pos;
    for (int i = 0; i < inFlight.size(); i++) begin
        pos = (start + i) % inFlight.size();
        if (!inFlight[pos].done) begin
            return pos;
        end
    end
    return -1;
endfunction

function automatic void squashAfter(input int pos);
    squashed.delete();
    while (inFlight.size() > pos + 1) begin
        squashed.push_back(inFlight.pop_back());
    end
endfunction

function automatic int freeSlots();
    return ROB_SIZE - inFlight.size();
endfunction

`endif

/* tests/robTb.sv */
`timescale 1ns/1ps

module robTb;
    localparam int ROB_SIZE       = 16;
    localparam int DISPATCH_WIDTH = 2;
    localparam int COMMIT_WIDTH   = 2;
    localparam int WB_PORTS       = 2;
    localparam int IDX_W          = $clog2(ROB_SIZE);
    localparam int PTR_W          = IDX_W + 1;
    localparam int NUM_W          = $clog2(COMMIT_WIDTH) + 1;
    localparam int PERIOD         = 100;
    localparam int RESET_CYCLES   = 16;
    localparam int RUN_CYCLES     = 1200;
    localparam int DRAIN_CYCLES   = 200;
    // reset, sweep, random run and drain all fit well inside this
    localparam int LIMIT_CYCLES   = 2000;

    logic clk;
    logic rst;
    logic [DISPATCH_WIDTH-1:0] dispEn;
    logic [DISPATCH_WIDTH-1:0] dispWe;
    uopPkg::memKindE [DISPATCH_WIDTH-1:0] dispMemKind;
    logic [DISPATCH_WIDTH-1:0][uopPkg::VREG_WIDTH-1:0] dispVrd;
    logic [DISPATCH_WIDTH-1:0][uopPkg::PREG_WIDTH-1:0] dispPrd;
    logic full;
    logic [PTR_W-1:0] tailPtr;
    logic [WB_PORTS-1:0] wbEn;
    logic [WB_PORTS-1:0][IDX_W-1:0] wbIdx;
    logic redirectEn;
    logic [PTR_W-1:0] redirectPtr;
    logic [COMMIT_WIDTH-1:0] commitEn;
    logic [COMMIT_WIDTH-1:0] commitWe;
    uopPkg::memKindE [COMMIT_WIDTH-1:0] commitMemKind;
    logic [COMMIT_WIDTH-1:0][uopPkg::VREG_WIDTH-1:0] commitVrd;
    logic [COMMIT_WIDTH-1:0][uopPkg::PREG_WIDTH-1:0] commitPrd;
    logic [NUM_W-1:0] commitNum;
    logic [NUM_W-1:0] commitWeNum;
    logic [NUM_W-1:0] commitLoadNum;
    logic [NUM_W-1:0] commitStoreNum;
    logic walk;
    logic walkStart;
    logic [COMMIT_WIDTH-1:0] walkEn;

    // values for the next rising edge
    logic [DISPATCH_WIDTH-1:0] planEn;
    logic [DISPATCH_WIDTH-1:0] planWe;
    uopPkg::memKindE [DISPATCH_WIDTH-1:0] planKind;
    logic [DISPATCH_WIDTH-1:0][uopPkg::VREG_WIDTH-1:0] planVrd;
    logic [DISPATCH_WIDTH-1:0][uopPkg::PREG_WIDTH-1:0] planPrd;
    logic [WB_PORTS-1:0] planWbEn;
    logic [WB_PORTS-1:0][IDX_W-1:0] planWbIdx;
    logic planRedirect;
    logic [PTR_W-1:0] planRedirectPtr;

    logic [PTR_W-1:0] expTail;
    logic [PTR_W-1:0] savedRedirectPtr;
    bit walkPending;
    bit sawWalk;
    int startSeen;
    int errors;
    int commitCount;
    int walkCount;
    int sweepCycles;
    int drainCycles;

    `include "robModel.svh"

    robTop robTop_inst (
        .clk(clk),
        .rst(rst),
        .dispEn(dispEn),
        .dispWe(dispWe),
        .dispMemKind(dispMemKind),
        .dispVrd(dispVrd),
        .dispPrd(dispPrd),
        .full(full),
        .tailPtr(tailPtr),
        .wbEn(wbEn),
        .wbIdx(wbIdx),
        .redirectEn(redirectEn),
        .redirectPtr(redirectPtr),
        .commitEn(commitEn),
        .commitWe(commitWe),
        .commitMemKind(commitMemKind),
        .commitVrd(commitVrd),
        .commitPrd(commitPrd),
        .commitNum(commitNum),
        .commitWeNum(commitWeNum),
        .commitLoadNum(commitLoadNum),
        .commitStoreNum(commitStoreNum),
        .walk(walk),
        .walkStart(walkStart),
        .walkEn(walkEn)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * PERIOD + 50 * PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic bit laneMatches(input int i, input robPkg::robEntryT e);
        return commitWe[i] == e.we && commitMemKind[i] == e.memKind
            && commitVrd[i] == e.vrd && commitPrd[i] == e.prd;
    endfunction

    task automatic driveInputs();
        @(posedge clk);
        dispEn <= planEn;
        dispWe <= planWe;
        dispMemKind <= planKind;
        dispVrd <= planVrd;
        dispPrd <= planPrd;
        wbEn <= planWbEn;
        wbIdx <= planWbIdx;
        redirectEn <= planRedirect;
        redirectPtr <= planRedirectPtr;
    endtask

    task automatic checkQuiet();
        if (commitEn != '0 || walk || walkStart || walkEn != '0) begin
            errors++;
            $display("ERROR at %0t: commit or walk output active before the sweep ended",
                $time);
        end
    endtask

    task automatic checkCommit();
        modelEntryT e;
        int n;
        int weN;
        int loadN;
        int storeN;
        n = 0;
        weN = 0;
        loadN = 0;
        storeN = 0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (commitEn[i]) begin
                if (i != n) begin
                    errors++;
                    $display("ERROR at %0t: commit lane %0d enabled after a hole", $time, i);
                end
                if (inFlight.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: commit lane %0d with nothing in flight", $time, i);
                end else begin
                    e = inFlight.pop_front();
                    if (!laneMatches(i, e.f)) begin
                        errors++;
                        $display("ERROR at %0t: commit lane %0d prd %0d, expected prd %0d",
                            $time, i, commitPrd[i], e.f.prd);
                    end
                    if (!e.done) begin
                        errors++;
                        $display("ERROR at %0t: slot %0d committed before its writeback",
                            $time, e.ptr[IDX_W-1:0]);
                    end
                    weN += int'(e.f.we);
                    loadN += int'(e.f.memKind == uopPkg::memLoad);
                    storeN += int'(e.f.memKind == uopPkg::memStore);
                end
                n++;
                commitCount++;
            end
        end
        if (int'(commitNum) != n || int'(commitWeNum) != weN
                || int'(commitLoadNum) != loadN || int'(commitStoreNum) != storeN) begin
            errors++;
            $display("ERROR at %0t: counts %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d",
                $time, commitNum, commitWeNum, commitLoadNum, commitStoreNum,
                n, weN, loadN, storeN);
        end
    endtask

    task automatic checkWalk();
        modelEntryT e;
        if (walkStart) begin
            if (!walkPending || sawWalk) begin
                errors++;
                $display("ERROR at %0t: walkStart outside the start of a walk", $time);
            end
            startSeen++;
        end
        if (walk) begin
            if (!walkPending) begin
                errors++;
                $display("ERROR at %0t: walk high without a redirect", $time);
            end
            sawWalk = 1'b1;
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (walkEn[i]) begin
                    if (squashed.size() == 0) begin
                        errors++;
                        $display("ERROR at %0t: walk lane %0d beyond the squashed entries",
                            $time, i);
                    end else begin
                        e = squashed.pop_front();
                        if (!laneMatches(i, e.f)) begin
                            errors++;
                            $display("ERROR at %0t: walk lane %0d fields differ from slot %0d",
                                $time, i, e.ptr[IDX_W-1:0]);
                        end
                    end
                end
            end
        end else if (walkEn != '0) begin
            errors++;
            $display("ERROR at %0t: walkEn set while walk is low", $time);
        end
        if (walkPending && sawWalk && !walk) begin
            if (squashed.size() != 0 || startSeen != 1) begin
                errors++;
                $display("ERROR at %0t: walk left %0d entries, saw %0d walkStart pulses",
                    $time, squashed.size(), startSeen);
            end
            if (tailPtr != savedRedirectPtr + PTR_W'(1)) begin
                errors++;
                $display("ERROR at %0t: tailPtr %0d after walk, expected %0d",
                    $time, tailPtr, savedRedirectPtr + PTR_W'(1));
            end
            walkPending = 1'b0;
            sawWalk = 1'b0;
            startSeen = 0;
            walkCount++;
        end
    endtask

    task automatic checkOccupancy();
        bit expFull;
        // free count in the DUT lags the model until the walk is over
        if (!walkPending) begin
            expFull = freeSlots() < $countones(dispEn);
            if (full != expFull) begin
                errors++;
                $display("ERROR at %0t: full is %0b, model expects %0b", $time, full, expFull);
            end
            if (tailPtr != expTail) begin
                errors++;
                $display("ERROR at %0t: tailPtr %0d, expected %0d", $time, tailPtr, expTail);
            end
        end
    endtask

    task automatic acceptOffer(output bit accepted);
        modelEntryT me;
        accepted = 1'b0;
        // no dispatch from the redirect cycle until the walk is over
        if (dispEn != '0 && !walkPending && freeSlots() >= $countones(dispEn)) begin
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (dispEn[i]) begin
                    me.ptr = expTail + PTR_W'(i);
                    me.f.we = dispWe[i];
                    me.f.memKind = dispMemKind[i];
                    me.f.vrd = dispVrd[i];
                    me.f.prd = dispPrd[i];
                    me.done = 1'b0;
                    inFlight.push_back(me);
                end
            end
            expTail = expTail + PTR_W'($countones(dispEn));
            accepted = 1'b1;
        end
    endtask

    task automatic planNext(input bit randomPhase, input bit accepted);
        robPkg::robEntryT e;
        int n;
        int pos;
        if (!randomPhase) begin
            planEn = '0;
        end else if (accepted || planEn == '0) begin
            n = int'(takeBits(2)) % (DISPATCH_WIDTH + 1);
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                e = randomEntry();
                planEn[i] = i < n;
                planWe[i] = e.we;
                planKind[i] = e.memKind;
                planVrd[i] = e.vrd;
                planPrd[i] = e.prd;
            end
        end
        // redirect at an entry that cannot commit before the walk
        planRedirect = 1'b0;
        if (randomPhase && !walkPending && inFlight.size() > 0 && takeBits(4) == 0) begin
            pos = findOpen(int'(takeBits(IDX_W)));
            if (pos >= 0) begin
                planRedirect = 1'b1;
                planRedirectPtr = inFlight[pos].ptr;
                savedRedirectPtr = inFlight[pos].ptr;
                squashAfter(pos);
                expTail = inFlight[pos].ptr + PTR_W'(1);
                walkPending = 1'b1;
            end
        end
        for (int p = 0; p < WB_PORTS; p++) begin
            planWbEn[p] = 1'b0;
            if (inFlight.size() > 0 && (!randomPhase || takeBits(1) != 0)) begin
                pos = findOpen(int'(takeBits(IDX_W)));
                if (pos >= 0) begin
                    planWbEn[p] = 1'b1;
                    planWbIdx[p] = inFlight[pos].ptr[IDX_W-1:0];
                    inFlight[pos].done = 1'b1;
                end
            end
        end
    endtask

    task automatic stepCycle(input bit randomPhase);
        bit accepted;
        driveInputs();
        @(negedge clk);
        checkCommit();
        checkWalk();
        checkOccupancy();
        acceptOffer(accepted);
        planNext(randomPhase, accepted);
    endtask

    initial begin
        rst = 1'b1;
        dispEn = '0;
        dispWe = '0;
        dispVrd = '0;
        dispPrd = '0;
        wbEn = '0;
        wbIdx = '0;
        redirectEn = 1'b0;
        redirectPtr = '0;
        planEn = '0;
        planWe = '0;
        planVrd = '0;
        planPrd = '0;
        planWbEn = '0;
        planWbIdx = '0;
        planRedirect = 1'b0;
        planRedirectPtr = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dispMemKind[i] = uopPkg::memNone;
            planKind[i] = uopPkg::memNone;
        end
        expTail = '0;
        errors = 0;

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            checkQuiet();
            if (!full) begin
                errors++;
                $display("ERROR at %0t: full low during reset", $time);
            end
        end

        // RAM sweep, one slot per cycle
        sweepCycles = 0;
        do begin
            @(negedge clk);
            checkQuiet();
            sweepCycles++;
        end while (full && sweepCycles < 4 * ROB_SIZE);
        if (full) begin
            errors++;
            $display("full never dropped after reset");
        end else if (sweepCycles != ROB_SIZE || tailPtr != '0) begin
            errors++;
            $display("ERROR at %0t: sweep took %0d cycles, tailPtr %0d",
                $time, sweepCycles, tailPtr);
        end

        for (int c = 0; c < RUN_CYCLES; c++) begin
            stepCycle(1'b1);
        end
        drainCycles = 0;
        while ((inFlight.size() > 0 || walkPending) && drainCycles < DRAIN_CYCLES) begin
            stepCycle(1'b0);
            drainCycles++;
        end
        if (inFlight.size() > 0 || walkPending) begin
            errors++;
            $display("drain did not finish, %0d entries never committed", inFlight.size());
        end

        $display("errors %0d, commits %0d, walks %0d", errors, commitCount, walkCount);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog/robCore.sv */
`timescale 1ns/1ps

module robCore #(
    parameter int ROB_SIZE       = 16,
    parameter int DISPATCH_WIDTH = 2,
    parameter int COMMIT_WIDTH   = 2
) (
    input  logic                                           clk,
    input  logic                                           rst,
    dispatchIfc.core                                       dispatch,
    commitIfc.source                                       commit,
    input  logic                                           redirectEn,
    input  logic [$clog2(ROB_SIZE):0]                      redirectPtr,
    input  logic                                           ramReady,
    output logic [DISPATCH_WIDTH-1:0]                      ramWe,
    output logic [DISPATCH_WIDTH-1:0][$clog2(ROB_SIZE)-1:0] ramWaddr,
    output logic [COMMIT_WIDTH-1:0][$clog2(ROB_SIZE)-1:0]   ramRaddr,
    input  robPkg::robEntryT [COMMIT_WIDTH-1:0]            ramRdata,
    output logic [COMMIT_WIDTH-1:0]                        clearEn,
    output logic [COMMIT_WIDTH-1:0][$clog2(ROB_SIZE)-1:0]   clearIdx,
    input  logic [COMMIT_WIDTH-1:0]                        headDone
);
    localparam int IDX_W  = $clog2(ROB_SIZE);
    localparam int PTR_W  = IDX_W + 1;
    localparam int NUM_W  = $clog2(COMMIT_WIDTH) + 1;
    localparam int DNUM_W = $clog2(DISPATCH_WIDTH) + 1;

    robPkg::robStateE state;
    logic [IDX_W-1:0] head;
    // top bit is the tail direction
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] freeCnt;
    logic [PTR_W-1:0] walkRemain;

    logic [DNUM_W-1:0] dispNum;
    logic [DNUM_W-1:0] acceptNum;
    logic startWalk;
    logic walkNow;
    logic [PTR_W-1:0] walkCnt;
    logic [PTR_W-1:0] walkLeft;
    logic [NUM_W-1:0] walkNum;
    logic [COMMIT_WIDTH-1:0] walkMask;
    logic [PTR_W-1:0] used;
    logic [COMMIT_WIDTH-1:0] commitSel;
    logic [COMMIT_WIDTH-1:0] commitFire;
    logic [COMMIT_WIDTH-1:0] weMask, loadMask, storeMask;

    function automatic logic [NUM_W-1:0] countOnes(input logic [COMMIT_WIDTH-1:0] v);
        logic [NUM_W-1:0] n;
        n = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            n = n + NUM_W'(v[i]);
        end
        return n;
    endfunction

    function automatic logic [COMMIT_WIDTH-1:0] laneMask(input logic [NUM_W-1:0] n);
        logic [COMMIT_WIDTH-1:0] m;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            m[i] = NUM_W'(i) < n;
        end
        return m;
    endfunction

    // dispatch side
    always_comb begin
        dispNum = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            dispNum = dispNum + DNUM_W'(dispatch.en[i]);
        end
    end

    assign dispatch.full = !ramReady || (freeCnt < PTR_W'(dispNum));
    assign dispatch.accept = !dispatch.full && state == robPkg::robIdle && !redirectEn;
    assign dispatch.tailPtr = tail;
    assign acceptNum = dispatch.accept ? dispNum : '0;

    for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : gWrite
        assign ramWe[i] = dispatch.en[i] && dispatch.accept;
        assign ramWaddr[i] = tail[IDX_W-1:0] + IDX_W'(i);
    end

    // walk covers redirectPtr+1 up to tail-1
    assign startWalk = state == robPkg::robIdle && redirectEn && ramReady;
    assign walkNow = startWalk || state == robPkg::robWalk;
    assign walkCnt = tail - redirectPtr - PTR_W'(1);
    assign walkLeft = (state == robPkg::robWalk) ? walkRemain : walkCnt;
    assign walkNum = (walkLeft < PTR_W'(COMMIT_WIDTH)) ? NUM_W'(walkLeft)
                                                       : NUM_W'(COMMIT_WIDTH);
    assign walkMask = laneMask(walkNum);

    // read lanes follow head, or walk down from the tail
    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : gRead
        assign ramRaddr[i] = walkNow ? tail[IDX_W-1:0] - IDX_W'(i + 1)
                                     : head + IDX_W'(i);
        assign clearIdx[i] = ramRaddr[i];
    end

    // longest done prefix among occupied head slots
    assign used = PTR_W'(ROB_SIZE) - freeCnt;
    always_comb begin
        logic run;
        run = 1'b1;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            run = run && headDone[i] && (PTR_W'(i) < used);
            commitSel[i] = run;
            weMask[i] = ramRdata[i].we;
            loadMask[i] = ramRdata[i].memKind == uopPkg::memLoad;
            storeMask[i] = ramRdata[i].memKind == uopPkg::memStore;
        end
    end

    assign commitFire = (state == robPkg::robIdle && !redirectEn && ramReady) ? commitSel : '0;
    // walked slots drop their done bit too
    assign clearEn = walkNow ? walkMask : commitFire;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= robPkg::robIdle;
            head <= '0;
            tail <= '0;
            freeCnt <= PTR_W'(ROB_SIZE);
            walkRemain <= '0;
            commit.en <= '0;
            commit.num <= '0;
            commit.weNum <= '0;
            commit.loadNum <= '0;
            commit.storeNum <= '0;
            commit.walk <= 1'b0;
            commit.walkStart <= 1'b0;
            commit.walkEn <= '0;
        end else begin
            commit.en <= commitFire;
            commit.num <= countOnes(commitFire);
            commit.weNum <= countOnes(commitFire & weMask);
            commit.loadNum <= countOnes(commitFire & loadMask);
            commit.storeNum <= countOnes(commitFire & storeMask);
            commit.walkStart <= startWalk;
            if (walkNow) begin
                commit.walkEn <= walkMask;
                tail <= tail - PTR_W'(walkNum);
                freeCnt <= freeCnt + PTR_W'(walkNum);
                walkRemain <= walkLeft - PTR_W'(walkNum);
            end else begin
                commit.walkEn <= '0;
                head <= head + IDX_W'(countOnes(commitFire));
                tail <= tail + PTR_W'(acceptNum);
                freeCnt <= freeCnt + PTR_W'(countOnes(commitFire)) - PTR_W'(acceptNum);
            end
            case (state)
                robPkg::robIdle: begin
                    if (startWalk) begin
                        state <= robPkg::robWalk;
                        commit.walk <= 1'b1;
                    end
                end
                robPkg::robWalk: begin
                    // last group is on the outputs now
                    if (walkRemain == '0) begin
                        state <= robPkg::robIdle;
                        commit.walk <= 1'b0;
                    end
                end
                default: state <= robPkg::robIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        commit.entry <= ramRdata;
    end

    assert property (@(posedge clk) disable iff (rst) freeCnt <= PTR_W'(ROB_SIZE))
        else $error("free count above buffer size");

    assert property (@(posedge clk) disable iff (rst)
        (COMMIT_WIDTH'(commit.en + 1'b1) & commit.en) == '0)
        else $error("commit lanes not contiguous");

    assert property (@(posedge clk) disable iff (rst)
        commit.walk |-> !(|ramWe))
        else $error("dispatch accepted during walk");

endmodule

/* verilog/robDataRam.sv */
`timescale 1ns/1ps

module robDataRam #(
    parameter int ROB_SIZE       = 16,
    parameter int DISPATCH_WIDTH = 2,
    parameter int COMMIT_WIDTH   = 2
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [DISPATCH_WIDTH-1:0]                      we,
    input  logic [DISPATCH_WIDTH-1:0][$clog2(ROB_SIZE)-1:0] waddr,
    input  robPkg::robEntryT [DISPATCH_WIDTH-1:0]          wdata,
    input  logic [COMMIT_WIDTH-1:0][$clog2(ROB_SIZE)-1:0]   raddr,
    output robPkg::robEntryT [COMMIT_WIDTH-1:0]            rdata,
    output logic                                           ready
);
    localparam int IDX_W = $clog2(ROB_SIZE);

    robPkg::robEntryT mem [ROB_SIZE];
    logic [IDX_W-1:0] sweepIdx;

    // one entry cleared per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == IDX_W'(ROB_SIZE - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ready) begin
            mem[sweepIdx] <= '0;
        end else begin
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (we[i]) begin
                    mem[waddr[i]] <= wdata[i];
                end
            end
        end
    end

    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : gRead
        assign rdata[i] = mem[raddr[i]];
    end

    // core hands out consecutive slots
    for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : gLaneA
        for (genvar j = i + 1; j < DISPATCH_WIDTH; j++) begin : gLaneB
            assert property (@(posedge clk) disable iff (rst)
                !(we[i] && we[j] && waddr[i] == waddr[j]))
                else $error("write lanes %0d and %0d hit one slot", i, j);
        end
    end

endmodule

/* verilog/robIfc.sv */
`timescale 1ns/1ps

interface dispatchIfc #(
    parameter int ROB_SIZE       = 16,
    parameter int DISPATCH_WIDTH = 2
);
    logic [DISPATCH_WIDTH-1:0]             en;
    robPkg::robEntryT [DISPATCH_WIDTH-1:0] entry;
    // direction bit on top
    logic [$clog2(ROB_SIZE):0]             tailPtr;
    logic                                  full;
    logic                                  accept;

    modport core (
        input  en,
        output tailPtr,
        output full,
        output accept
    );

    modport source (
        output en,
        output entry,
        input  tailPtr,
        input  full,
        input  accept
    );
endinterface

interface commitIfc #(
    parameter int COMMIT_WIDTH = 2
);
    logic [COMMIT_WIDTH-1:0]             en;
    robPkg::robEntryT [COMMIT_WIDTH-1:0] entry;
    logic [$clog2(COMMIT_WIDTH):0]       num;
    logic [$clog2(COMMIT_WIDTH):0]       weNum;
    logic [$clog2(COMMIT_WIDTH):0]       loadNum;
    logic [$clog2(COMMIT_WIDTH):0]       storeNum;
    logic                                walk;
    logic                                walkStart;
    // youngest entry on lane 0
    logic [COMMIT_WIDTH-1:0]             walkEn;

    modport source (
        output en, entry, num, weNum, loadNum, storeNum,
        output walk, walkStart, walkEn
    );

    modport sink (
        input en, entry, num, weNum, loadNum, storeNum,
        input walk, walkStart, walkEn
    );
endinterface

/* verilog/robPkg.sv */
package robPkg;

    // one buffer slot, 14 bits
    typedef struct packed {
        logic                          we;
        uopPkg::memKindE               memKind;
        logic [uopPkg::VREG_WIDTH-1:0] vrd;
        logic [uopPkg::PREG_WIDTH-1:0] prd;
    } robEntryT;

    // walk undoes rename mappings of squashed entries
    typedef enum logic {
        robIdle,
        robWalk
    } robStateE;

endpackage

/* verilog/robTop.sv */
`timescale 1ns/1ps

module robTop #(
    parameter int ROB_SIZE       = 16,
    parameter int DISPATCH_WIDTH = 2,
    parameter int COMMIT_WIDTH   = 2,
    parameter int WB_PORTS       = 2
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic [DISPATCH_WIDTH-1:0]                          dispEn,
    input  logic [DISPATCH_WIDTH-1:0]                          dispWe,
    input  uopPkg::memKindE [DISPATCH_WIDTH-1:0]               dispMemKind,
    input  logic [DISPATCH_WIDTH-1:0][uopPkg::VREG_WIDTH-1:0]  dispVrd,
    input  logic [DISPATCH_WIDTH-1:0][uopPkg::PREG_WIDTH-1:0]  dispPrd,
    output logic                                               full,
    output logic [$clog2(ROB_SIZE):0]                          tailPtr,
    input  logic [WB_PORTS-1:0]                                wbEn,
    input  logic [WB_PORTS-1:0][$clog2(ROB_SIZE)-1:0]           wbIdx,
    input  logic                                               redirectEn,
    input  logic [$clog2(ROB_SIZE):0]                          redirectPtr,
    output logic [COMMIT_WIDTH-1:0]                            commitEn,
    output logic [COMMIT_WIDTH-1:0]                            commitWe,
    output uopPkg::memKindE [COMMIT_WIDTH-1:0]                 commitMemKind,
    output logic [COMMIT_WIDTH-1:0][uopPkg::VREG_WIDTH-1:0]    commitVrd,
    output logic [COMMIT_WIDTH-1:0][uopPkg::PREG_WIDTH-1:0]    commitPrd,
    output logic [$clog2(COMMIT_WIDTH):0]                      commitNum,
    output logic [$clog2(COMMIT_WIDTH):0]                      commitWeNum,
    output logic [$clog2(COMMIT_WIDTH):0]                      commitLoadNum,
    output logic [$clog2(COMMIT_WIDTH):0]                      commitStoreNum,
    output logic                                               walk,
    output logic                                               walkStart,
    output logic [COMMIT_WIDTH-1:0]                            walkEn
);
    localparam int IDX_W = $clog2(ROB_SIZE);

    logic [DISPATCH_WIDTH-1:0] ramWe;
    logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] ramWaddr;
    logic [COMMIT_WIDTH-1:0][IDX_W-1:0] ramRaddr;
    robPkg::robEntryT [COMMIT_WIDTH-1:0] ramRdata;
    logic ramReady;
    logic [COMMIT_WIDTH-1:0] clearEn;
    logic [COMMIT_WIDTH-1:0][IDX_W-1:0] clearIdx;
    logic [COMMIT_WIDTH-1:0] headDone;

    dispatchIfc #(.ROB_SIZE(ROB_SIZE), .DISPATCH_WIDTH(DISPATCH_WIDTH)) dispBus ();
    commitIfc #(.COMMIT_WIDTH(COMMIT_WIDTH)) commitBus ();

    assign dispBus.en = dispEn;
    for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : gDisp
        assign dispBus.entry[i].we = dispWe[i];
        assign dispBus.entry[i].memKind = dispMemKind[i];
        assign dispBus.entry[i].vrd = dispVrd[i];
        assign dispBus.entry[i].prd = dispPrd[i];
    end
    assign full = dispBus.full;
    assign tailPtr = dispBus.tailPtr;

    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : gCommit
        assign commitWe[i] = commitBus.entry[i].we;
        assign commitMemKind[i] = commitBus.entry[i].memKind;
        assign commitVrd[i] = commitBus.entry[i].vrd;
        assign commitPrd[i] = commitBus.entry[i].prd;
    end
    assign commitEn = commitBus.en;
    assign commitNum = commitBus.num;
    assign commitWeNum = commitBus.weNum;
    assign commitLoadNum = commitBus.loadNum;
    assign commitStoreNum = commitBus.storeNum;
    assign walk = commitBus.walk;
    assign walkStart = commitBus.walkStart;
    assign walkEn = commitBus.walkEn;

    robCore #(
        .ROB_SIZE(ROB_SIZE),
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) robCore_inst (
        .clk(clk),
        .rst(rst),
        .dispatch(dispBus),
        .commit(commitBus),
        .redirectEn(redirectEn),
        .redirectPtr(redirectPtr),
        .ramReady(ramReady),
        .ramWe(ramWe),
        .ramWaddr(ramWaddr),
        .ramRaddr(ramRaddr),
        .ramRdata(ramRdata),
        .clearEn(clearEn),
        .clearIdx(clearIdx),
        .headDone(headDone)
    );

    robDataRam #(
        .ROB_SIZE(ROB_SIZE),
        .DISPATCH_WIDTH(DISPATCH_WIDTH),
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) robDataRam_inst (
        .clk(clk),
        .rst(rst),
        .we(ramWe),
        .waddr(ramWaddr),
        .wdata(dispBus.entry),
        .raddr(ramRaddr),
        .rdata(ramRdata),
        .ready(ramReady)
    );

    robWbTracker #(
        .ROB_SIZE(ROB_SIZE),
        .WB_PORTS(WB_PORTS),
        .COMMIT_WIDTH(COMMIT_WIDTH)
    ) robWbTracker_inst (
        .clk(clk),
        .rst(rst),
        .wbEn(wbEn),
        .wbIdx(wbIdx),
        .clearEn(clearEn),
        .clearIdx(clearIdx),
        .headIdx(ramRaddr),
        .headDone(headDone)
    );

endmodule

/* verilog/robWbTracker.sv */
`timescale 1ns/1ps

module robWbTracker #(
    parameter int ROB_SIZE     = 16,
    parameter int WB_PORTS     = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [WB_PORTS-1:0]                          wbEn,
    input  logic [WB_PORTS-1:0][$clog2(ROB_SIZE)-1:0]     wbIdx,
    input  logic [COMMIT_WIDTH-1:0]                      clearEn,
    input  logic [COMMIT_WIDTH-1:0][$clog2(ROB_SIZE)-1:0] clearIdx,
    input  logic [COMMIT_WIDTH-1:0][$clog2(ROB_SIZE)-1:0] headIdx,
    output logic [COMMIT_WIDTH-1:0]                      headDone
);
    logic [ROB_SIZE-1:0] done;

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= '0;
        end else begin
            for (int i = 0; i < COMMIT_WIDTH; i++) begin
                if (clearEn[i]) begin
                    done[clearIdx[i]] <= 1'b0;
                end
            end
            // writeback last so a set wins
            for (int i = 0; i < WB_PORTS; i++) begin
                if (wbEn[i]) begin
                    done[wbIdx[i]] <= 1'b1;
                end
            end
        end
    end

    for (genvar i = 0; i < COMMIT_WIDTH; i++) begin : gHead
        assign headDone[i] = done[headIdx[i]];
    end

    // each entry is written back once per allocation
    for (genvar i = 0; i < WB_PORTS; i++) begin : gWbCheck
        assert property (@(posedge clk) disable iff (rst)
            wbEn[i] |-> !done[wbIdx[i]])
            else $error("writeback port %0d hit a done entry", i);
    end

endmodule

/* verilog/uopPkg.sv */
package uopPkg;

    // architectural register number
    localparam int VREG_WIDTH = 5;

    // physical register number
    localparam int PREG_WIDTH = 6;

    // memory side of an operation
    typedef enum logic [1:0] {
        memNone,
        memLoad,
        memStore
    } memKindE;

endpackage
